// ==== common/riscv_pkg.sv ====
package riscv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_i_type_l = 7'b0000011,  // lw
        op_i_type   = 7'b0010011,  // addi, xori, ori, andi, slli, srli
        op_s_type   = 7'b0100011,  // sw
        op_r_type   = 7'b0110011,
        op_b_type   = 7'b1100011,
        op_j_type   = 7'b1101111   // jal
    } opcode_e;

    typedef enum logic [3:0] {
        alu_op_add = 4'd0,
        alu_op_sub = 4'd1,
        alu_op_and = 4'd2,
        alu_op_or  = 4'd3,
        alu_op_xor = 4'd4,
        alu_op_sll = 4'd5,
        alu_op_srl = 4'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_src_itype = 2'd0,
        imm_src_stype = 2'd1,
        imm_src_btype = 2'd2,
        imm_src_jtype = 2'd3
    } imm_src_e;

    typedef enum logic [1:0] {
        res_src_alu_out   = 2'd0,
        res_src_read_data = 2'd1,
        res_src_pc_plus_4 = 2'd2
    } res_src_e;

    typedef enum logic {
        pc_src_plus_4   = 1'b0,
        pc_src_plus_off = 1'b1
    } pc_src_e;

    typedef enum logic {
        alu_src_reg     = 1'b0,
        alu_src_ext_imm = 1'b1
    } alu_src_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;
        logic ov;
    } alu_flags_t;

    // instruction word, one view per encoding format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } instr_b_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_j_t j;
    } instr_u;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        alu_src_e alu_src;
        res_src_e result_src;
        pc_src_e  pc_src;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
    } ctrl_t;

endpackage

// ==== riscv/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  riscv_pkg::alu_op_e    op,
    output logic [31:0]           result,
    output riscv_pkg::alu_flags_t flags
);
    import riscv_pkg::*;

    logic        is_sub;
    logic        is_arith;
    logic [31:0] b_eff;
    logic [32:0] sum;

    assign is_sub   = (op == alu_op_sub);
    assign is_arith = (op == alu_op_add) || is_sub;
    assign b_eff    = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {32'd0, is_sub};  // a + ~b + 1 on sub

    always_comb begin
        case (op)
            alu_op_and: result = a & b;
            alu_op_or:  result = a | b;
            alu_op_xor: result = a ^ b;
            alu_op_sll: result = a << b[4:0];
            alu_op_srl: result = a >> b[4:0];
            default:    result = sum[31:0];
        endcase
    end

    always_comb begin
        flags.neg  = result[31];
        flags.zero = (result == 32'd0);
        flags.cout = is_arith & sum[32];  // set means no borrow on sub
        // same operand signs but the sum sign differs
        flags.ov   = is_arith & (a[31] == b_eff[31]) & (sum[31] != a[31]);
    end
endmodule

// ==== riscv/controller.sv ====
`timescale 1ns/1ps

module alu_dec (
    input  riscv_pkg::opcode_e op,
    input  logic [2:0]         funct3,
    input  logic [6:0]         funct7,
    output riscv_pkg::alu_op_e alu_ctrl
);
    import riscv_pkg::*;

    alu_op_e arith_op;  // shared funct3 decode for R and I forms

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alu_op_add;
            3'b001:  arith_op = alu_op_sll;
            3'b100:  arith_op = alu_op_xor;
            3'b101:  arith_op = alu_op_srl;
            3'b110:  arith_op = alu_op_or;
            3'b111:  arith_op = alu_op_and;
            default: arith_op = alu_op_add;  // slt/sltu not supported
        endcase
    end

    always_comb begin
        case (op)
            op_r_type: begin
                if (funct3 == 3'b000 && funct7[5])
                    alu_ctrl = alu_op_sub;
                else
                    alu_ctrl = arith_op;
            end
            op_i_type:   alu_ctrl = arith_op;  // no subi
            op_b_type:   alu_ctrl = alu_op_sub;  // compare via flags
            default:     alu_ctrl = alu_op_add;  // address calc, jal, no-op
        endcase
    end
endmodule

module controller (
    input  logic                  rst_n,
    input  riscv_pkg::instr_u     instr,
    input  riscv_pkg::alu_flags_t alu_flags,
    output riscv_pkg::ctrl_t      ctrl
);
    import riscv_pkg::*;

    alu_op_e alu_ctrl;
    pc_src_e br_src;
    ctrl_t   dec;

    alu_dec u_alu_dec (
        .op       (instr.r.opcode),
        .funct3   (instr.r.funct3),
        .funct7   (instr.r.funct7),
        .alu_ctrl (alu_ctrl)
    );

    // branch decision from rs1 - rs2 flags
    always_comb begin
        case (instr.b.funct3)
            3'b000:  br_src = alu_flags.zero ? pc_src_plus_off : pc_src_plus_4;  // beq
            3'b001:  br_src = alu_flags.zero ? pc_src_plus_4 : pc_src_plus_off;  // bne
            3'b100:  br_src = (alu_flags.neg ^ alu_flags.ov) ? pc_src_plus_off : pc_src_plus_4;
            3'b101:  br_src = (alu_flags.neg ^ alu_flags.ov) ? pc_src_plus_4 : pc_src_plus_off;
            3'b110:  br_src = alu_flags.cout ? pc_src_plus_4 : pc_src_plus_off;  // bltu, borrow
            3'b111:  br_src = alu_flags.cout ? pc_src_plus_off : pc_src_plus_4;  // bgeu
            default: br_src = pc_src_plus_4;
        endcase
    end

    // main decoder, starts from a no-op and sets what differs
    always_comb begin
        dec.reg_we     = 1'b0;
        dec.mem_we     = 1'b0;
        dec.alu_src    = alu_src_reg;
        dec.result_src = res_src_alu_out;
        dec.pc_src     = pc_src_plus_4;
        dec.imm_src    = imm_src_itype;
        dec.alu_ctrl   = alu_ctrl;
        case (instr.r.opcode)
            op_i_type_l: begin
                dec.reg_we     = 1'b1;
                dec.alu_src    = alu_src_ext_imm;
                dec.result_src = res_src_read_data;
            end
            op_i_type: begin
                dec.reg_we  = 1'b1;
                dec.alu_src = alu_src_ext_imm;
            end
            op_s_type: begin
                dec.mem_we  = 1'b1;
                dec.alu_src = alu_src_ext_imm;
                dec.imm_src = imm_src_stype;
            end
            op_r_type:   dec.reg_we = 1'b1;
            op_b_type: begin
                dec.pc_src  = br_src;
                dec.imm_src = imm_src_btype;
            end
            op_j_type: begin
                dec.reg_we     = 1'b1;
                dec.result_src = res_src_pc_plus_4;  // link address
                dec.pc_src     = pc_src_plus_off;
                dec.imm_src    = imm_src_jtype;
            end
            default: ;
        endcase
    end

    always_comb begin
        ctrl = dec;
        if (!rst_n) begin
            ctrl.reg_we = 1'b0;  // no side effects while in reset
            ctrl.mem_we = 1'b0;
        end
    end
endmodule

// ==== riscv/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  riscv_pkg::instr_u     instr,
    input  riscv_pkg::ctrl_t      ctrl,
    output riscv_pkg::alu_flags_t alu_flags,
    output logic [31:0]           pc,
    output logic [31:0]           alu_out,
    output logic [31:0]           write_data,
    input  logic [31:0]           read_data
);
    import riscv_pkg::*;

    logic [31:0] pc_plus_4;
    logic [31:0] pc_next;
    logic [31:0] imm_ext;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] result;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= 32'd0;
        else
            pc <= pc_next;
    end

    assign pc_plus_4 = pc + 32'd4;
    assign pc_next   = (ctrl.pc_src == pc_src_plus_off) ? pc + imm_ext : pc_plus_4;

    // sign extension per format
    always_comb begin
        case (ctrl.imm_src)
            imm_src_stype: imm_ext = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            imm_src_btype: imm_ext = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                                      instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            imm_src_jtype: imm_ext = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                                      instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default:       imm_ext = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        endcase
    end

    reg_file u_reg_file (
        .clk (clk),
        .we  (ctrl.reg_we),
        .ra1 (instr.r.rs1),
        .ra2 (instr.r.rs2),
        .wa  (instr.r.rd),
        .wd  (result),
        .rd1 (src_a),
        .rd2 (write_data)  // rs2 doubles as store data
    );

    assign src_b = (ctrl.alu_src == alu_src_ext_imm) ? imm_ext : write_data;

    alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (ctrl.alu_ctrl),
        .result (alu_out),
        .flags  (alu_flags)
    );

    // write-back select
    always_comb begin
        case (ctrl.result_src)
            res_src_read_data: result = read_data;
            res_src_pc_plus_4: result = pc_plus_4;
            default:           result = alu_out;
        endcase
    end
endmodule

// ==== riscv/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // reads see the old value during a write cycle
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];
endmodule

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_rdata,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_we,
    input  logic [31:0] dmem_rdata
);
    import riscv_pkg::*;

    instr_u     instr;
    ctrl_t      ctrl;
    alu_flags_t alu_flags;

    assign instr   = imem_rdata;   // fetch is combinational
    assign dmem_we = ctrl.mem_we;  // commits at the next edge

    controller u_controller (
        .rst_n     (rst_n),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .ctrl       (ctrl),
        .alu_flags  (alu_flags),
        .pc         (imem_addr),
        .alu_out    (dmem_addr),
        .write_data (dmem_wdata),
        .read_data  (dmem_rdata)
    );
endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_rv_core -f rv_core.f -o sim_rv_core

# the log decides pass or fail
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"

// ==== rv_core.f ====
+incdir+tb
common/riscv_pkg.sv
riscv/alu.sv
riscv/reg_file.sv
riscv/controller.sv
riscv/datapath.sv
rtl/rv_core_top.sv
tb/tb_rv_core.sv

// ==== tb/rv_iss.svh ====
`ifndef rv_iss_svh
`define rv_iss_svh

// shadow architectural state, one instruction per cycle
logic [31:0] shadow_regs [0:31];
logic [31:0] shadow_pc;
logic [31:0] shadow_mem [0:63];

// funct3 codes valid for the R, I and B groups of the subset
function automatic logic [2:0] pick_funct3(input logic [2:0] sel);
    case (sel)
        3'd0, 3'd6: pick_funct3 = 3'b000;
        3'd1:       pick_funct3 = 3'b001;
        3'd2, 3'd7: pick_funct3 = 3'b100;
        3'd3:       pick_funct3 = 3'b101;
        3'd4:       pick_funct3 = 3'b110;
        default:    pick_funct3 = 3'b111;
    endcase
endfunction

function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  arith_result = alt ? a - b : a + b;
        3'b001:  arith_result = a << b[4:0];
        3'b100:  arith_result = a ^ b;
        3'b101:  arith_result = a >> b[4:0];  // logical only
        3'b110:  arith_result = a | b;
        3'b111:  arith_result = a & b;
        default: arith_result = 32'd0;
    endcase
endfunction

function automatic instr_u random_instr();
    instr_u      w;
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] off;
    r = $urandom;
    s = $urandom;
    w = s;  // register fields and immediates start random
    // jump distance of -2..6 words, never 0
    off = ({29'd0, r[10:8]} + ((r[10:8] >= 3'd2) ? 32'd1 : 32'd0) - 32'd2) << 2;
    case (r[3:0])
        4'd0, 4'd1: begin
            w.i.opcode   = op_i_type_l;
            w.i.funct3   = 3'b010;
            w.i.rs1      = 5'd0;
            w.i.imm_11_0 = {4'd0, r[21:16], 2'b00};
        end
        4'd2, 4'd3, 4'd4: begin
            w.i.opcode = op_i_type;
            w.i.funct3 = pick_funct3(r[6:4]);
            if (w.i.funct3 == 3'b001 || w.i.funct3 == 3'b101)
                w.i.imm_11_0 = {7'd0, s[24:20]};  // slli / srli
        end
        4'd5, 4'd6, 4'd7: begin
            w.s.opcode   = op_s_type;
            w.s.funct3   = 3'b010;
            w.s.rs1      = 5'd0;
            w.s.imm_11_5 = {4'd0, r[21:19]};
            w.s.imm_4_0  = {r[18:16], 2'b00};
        end
        4'd11, 4'd12: begin
            w.b.opcode   = op_b_type;
            w.b.funct3   = pick_funct3(r[6:4]);
            if (r[12:11] == 2'd0)
                w.b.rs2 = w.b.rs1;  // equal operands now and then
            w.b.imm_12   = off[12];
            w.b.imm_11   = off[11];
            w.b.imm_10_5 = off[10:5];
            w.b.imm_4_1  = off[4:1];
        end
        4'd13: begin
            w.j.opcode    = op_j_type;
            w.j.imm_20    = off[20];
            w.j.imm_19_12 = off[19:12];
            w.j.imm_11    = off[11];
            w.j.imm_10_1  = off[10:1];
        end
        4'd14: begin
            case (r[5:4])
                2'd0:    w.r.opcode = opcode_e'(7'b0110111);  // lui
                2'd1:    w.r.opcode = opcode_e'(7'b0010111);  // auipc
                2'd2:    w.r.opcode = opcode_e'(7'b1100111);  // jalr
                default: w.r.opcode = opcode_e'(7'b0001111);  // fence
            endcase
        end
        default: begin
            w.r.opcode = op_r_type;
            w.r.funct3 = pick_funct3(r[6:4]);
            w.r.funct7 = (w.r.funct3 == 3'b000 && r[7]) ? 7'b0100000 : 7'b0000000;
        end
    endcase
    return w;
endfunction

task automatic execute_instr(input instr_u w, output logic st_en,
                             output logic [31:0] st_addr, output logic [31:0] st_data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [31:0] wr_val;
    logic        wr_en;
    logic        taken;
    a       = shadow_regs[w.r.rs1];
    b       = shadow_regs[w.r.rs2];
    imm_i   = 32'($signed(w.i.imm_11_0));
    imm_s   = 32'($signed({w.s.imm_11_5, w.s.imm_4_0}));
    imm_b   = 32'($signed({w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0}));
    imm_j   = 32'($signed({w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0}));
    next_pc = shadow_pc + 32'd4;
    wr_en   = 1'b0;
    wr_val  = 32'd0;
    taken   = 1'b0;
    st_en   = 1'b0;
    st_addr = 32'd0;
    st_data = 32'd0;
    case (w.r.opcode)
        op_i_type_l: begin
            addr   = a + imm_i;
            wr_en  = 1'b1;
            wr_val = shadow_mem[addr[7:2]];
        end
        op_i_type: begin
            wr_en  = 1'b1;
            wr_val = arith_result(w.i.funct3, 1'b0, a, imm_i);
        end
        op_s_type: begin
            st_en   = 1'b1;
            st_addr = a + imm_s;
            st_data = b;
            shadow_mem[st_addr[7:2]] = b;
        end
        op_r_type: begin
            wr_en  = 1'b1;
            wr_val = arith_result(w.r.funct3, w.r.funct7[5], a, b);
        end
        op_b_type: begin
            case (w.b.funct3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                3'b111:  taken = (a >= b);
                default: taken = 1'b0;
            endcase
            if (taken)
                next_pc = shadow_pc + imm_b;
        end
        op_j_type: begin
            wr_en   = 1'b1;
            wr_val  = shadow_pc + 32'd4;
            next_pc = shadow_pc + imm_j;
        end
        default: ;  // anything else leaves the state alone
    endcase
    if (wr_en && w.r.rd != 5'd0)
        shadow_regs[w.r.rd] = wr_val;
    shadow_pc = next_pc;
endtask

`endif

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
    import riscv_pkg::*;

    localparam int num_cycles     = 2000;
    localparam int reset_cycles   = 3;
    localparam int timeout_cycles = num_cycles + 100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    int unsigned cycle_count = 0;
    int unsigned store_count = 0;

    `include "rv_iss.svh"

    always #5 clk = ~clk;

    rv_core_top u_rv_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_we(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // data memory starts random, registers are loaded by a preamble of addi
    task automatic load_program();
        instr_u w;
        for (int i = 0; i < 64; i++) begin
            dmem[i]       = $urandom;
            shadow_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++)
            shadow_regs[i] = 32'd0;
        shadow_pc = 32'd0;
        for (int i = 1; i < 32; i++) begin
            w            = '0;
            w.i.opcode   = op_i_type;
            w.i.rd       = 5'(i);
            w.i.imm_11_0 = 12'($urandom);
            imem[i - 1]  = w;
        end
        for (int i = 31; i < 64; i++)
            imem[i] = random_instr();
    endtask

    // one instruction, inputs applied after the falling edge
    task automatic run_cycle(output logic we_seen, output logic [31:0] addr_seen,
                             output logic [31:0] data_seen);
        instr_u      w;
        logic        exp_we;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        check_word("imem_addr", imem_addr, shadow_pc);
        w          = imem[imem_addr[7:2]];
        imem_rdata = w;
        #1;
        dmem_rdata = dmem[dmem_addr[7:2]];  // read port follows the address
        #1;
        execute_instr(w, exp_we, exp_addr, exp_data);
        check_we("dmem_we", dmem_we, exp_we);
        if (exp_we) begin
            check_word("dmem_addr", dmem_addr, exp_addr);
            check_word("dmem_wdata", dmem_wdata, exp_data);
            store_count++;
        end
        we_seen   = dmem_we;
        addr_seen = dmem_addr;
        data_seen = dmem_wdata;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, run still going after %0d cycles", cycle_count);
            stop_on_failure();
        end
    end

    initial begin
        instr_u      probe;
        logic        we_seen;
        logic [31:0] addr_seen;
        logic [31:0] data_seen;
        rst_n      = 1'b0;
        imem_rdata = 32'd0;
        dmem_rdata = 32'd0;
        void'($urandom(32'hd457_fc28));
        load_program();

        // a store word held on the bus must not write during reset
        probe          = '0;
        probe.s.opcode = op_s_type;
        probe.s.funct3 = 3'b010;
        probe.s.rs2    = 5'd1;
        imem_rdata     = probe;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        check_we("dmem_we", dmem_we, 1'b0);
        check_word("imem_addr", imem_addr, 32'd0);
        rst_n = 1'b1;

        for (int n = 0; n < num_cycles; n++) begin
            run_cycle(we_seen, addr_seen, data_seen);
            @(posedge clk);
            if (we_seen)
                dmem[addr_seen[7:2]] = data_seen;  // commit at the rising edge
            @(negedge clk);
        end

        $display("%0d instructions checked, %0d stores compared", num_cycles, store_count);
        $display("all tests passed");
        $finish;
    end
endmodule
